// ==== design/holy_core_pkg.sv ====
package holy_core_pkg;

    localparam int XLEN = 32;

    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_MISC   = 7'b0001111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_control_t;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_source_t;

    typedef enum logic {ALU_SOURCE_RD, ALU_SOURCE_IMM} alu_source_t;

    typedef enum logic [1:0] {
        WB_SOURCE_ALU_RESULT, WB_SOURCE_MEM_READ, WB_SOURCE_PC_PLUS_FOUR, WB_SOURCE_SECOND_ADD
    } wb_source_t;

    typedef enum logic [1:0] {SOURCE_PC_PLUS_4, SOURCE_PC_SECOND_ADD, SOURCE_PC_ALU} pc_source_t;

    typedef enum logic [1:0] {
        SECOND_ADDER_SOURCE_PC, SECOND_ADDER_SOURCE_ZERO, SECOND_ADDER_SOURCE_RD
    } second_add_source_t;

    // Full decoder output, each unit picks its own fields
    typedef struct packed {
        alu_control_t       alu_control;
        imm_source_t        imm_source;
        alu_source_t        alu_source;
        wb_source_t         wb_source;
        pc_source_t         pc_source;
        second_add_source_t second_add_source;
        logic               reg_write;
        logic               mem_read;
        logic               mem_write;
        logic [2:0]         funct3;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [3:0]      byte_en;
        logic            write;
    } dmem_req_t;

endpackage

// ==== design/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit import holy_core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  ctrl_t           i_ctrl,
    input  logic            i_take_branch,
    input  logic [XLEN-1:0] i_imm,
    input  logic [XLEN-1:0] i_rs1_data,
    input  logic [XLEN-1:0] i_alu_result,
    output logic [XLEN-1:0] o_pc,
    output logic [XLEN-1:0] o_pc_plus_four,
    output logic [XLEN-1:0] o_second_add_result
);

    logic [XLEN-1:0] second_base;
    logic [XLEN-1:0] pc_next;

    // Second adder base, zero for LUI
    always_comb begin
        case (i_ctrl.second_add_source)
            SECOND_ADDER_SOURCE_PC: second_base = o_pc;
            SECOND_ADDER_SOURCE_RD: second_base = i_rs1_data;
            default:                second_base = '0;
        endcase
    end

    assign o_second_add_result = second_base + i_imm;
    assign o_pc_plus_four      = o_pc + XLEN'(4);

    always_comb begin
        case (i_ctrl.pc_source)
            SOURCE_PC_SECOND_ADD: pc_next = i_take_branch ? o_second_add_result : o_pc_plus_four;
            // JALR target, bit 0 dropped
            SOURCE_PC_ALU:        pc_next = {i_alu_result[XLEN-1:1], 1'b0};
            default:              pc_next = o_pc_plus_four;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_pc <= RESET_PC;
        end else begin
            o_pc <= pc_next;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) o_pc[1:0] == 2'b00);

endmodule

// ==== design/control.sv ====
`timescale 1ns/1ps

module control import holy_core_pkg::*; (
    input  logic [XLEN-1:0] i_instr,
    input  logic            i_alu_zero,
    input  logic            i_alu_last_bit,
    output ctrl_t           o_ctrl,
    output logic            o_take_branch
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    logic       cond_met;

    assign opcode    = opcode_t'(i_instr[6:0]);
    assign funct3    = i_instr[14:12];
    assign funct7_b5 = i_instr[30];

    // SUB only exists in register form, SRA in both
    function automatic alu_control_t arith_op(input logic [2:0] f3, input logic f7_b5,
                                              input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && f7_b5) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return f7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        // All-zero bundle is a no-op
        o_ctrl = '0;
        o_ctrl.funct3 = funct3;
        case (opcode)
            OPCODE_OP: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_control = arith_op(funct3, funct7_b5, 1'b1);
            end
            OPCODE_OP_IMM: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_source  = ALU_SOURCE_IMM;
                o_ctrl.alu_control = arith_op(funct3, funct7_b5, 1'b0);
            end
            OPCODE_LOAD: begin
                o_ctrl.reg_write  = 1'b1;
                o_ctrl.mem_read   = 1'b1;
                o_ctrl.alu_source = ALU_SOURCE_IMM;
                o_ctrl.wb_source  = WB_SOURCE_MEM_READ;
            end
            OPCODE_STORE: begin
                o_ctrl.mem_write  = 1'b1;
                o_ctrl.imm_source = IMM_S;
                o_ctrl.alu_source = ALU_SOURCE_IMM;
            end
            OPCODE_BRANCH: begin
                o_ctrl.imm_source = IMM_B;
                o_ctrl.pc_source  = SOURCE_PC_SECOND_ADD;
                case (funct3[2:1])
                    2'b10:   o_ctrl.alu_control = ALU_SLT;
                    2'b11:   o_ctrl.alu_control = ALU_SLTU;
                    default: o_ctrl.alu_control = ALU_SUB;
                endcase
            end
            OPCODE_JAL: begin
                o_ctrl.reg_write  = 1'b1;
                o_ctrl.imm_source = IMM_J;
                o_ctrl.pc_source  = SOURCE_PC_SECOND_ADD;
                o_ctrl.wb_source  = WB_SOURCE_PC_PLUS_FOUR;
            end
            OPCODE_JALR: begin
                o_ctrl.reg_write         = 1'b1;
                o_ctrl.alu_source        = ALU_SOURCE_IMM;
                o_ctrl.pc_source         = SOURCE_PC_ALU;
                o_ctrl.wb_source         = WB_SOURCE_PC_PLUS_FOUR;
                o_ctrl.second_add_source = SECOND_ADDER_SOURCE_RD;
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                o_ctrl.reg_write  = 1'b1;
                o_ctrl.imm_source = IMM_U;
                o_ctrl.wb_source  = WB_SOURCE_SECOND_ADD;
                if (opcode == OPCODE_LUI) begin
                    o_ctrl.second_add_source = SECOND_ADDER_SOURCE_ZERO;
                end
            end
            default: ;
        endcase
    end

    // Equality from zero flag, ordering from SLT/SLTU result bit
    always_comb begin
        case (funct3)
            3'b000:         cond_met = i_alu_zero;
            3'b001:         cond_met = !i_alu_zero;
            3'b100, 3'b110: cond_met = i_alu_last_bit;
            3'b101, 3'b111: cond_met = !i_alu_last_bit;
            default:        cond_met = 1'b0;
        endcase
        // JAL is an always-taken redirect
        o_take_branch = (opcode == OPCODE_BRANCH && cond_met) || opcode == OPCODE_JAL;
    end

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile import holy_core_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [XLEN-1:0] i_instr,
    input  ctrl_t           i_ctrl,
    input  logic [XLEN-1:0] i_alu_result,
    input  logic [XLEN-1:0] i_load_data,
    input  logic [XLEN-1:0] i_pc_plus_four,
    input  logic [XLEN-1:0] i_second_add_result,
    output logic [XLEN-1:0] o_rs1_data,
    output logic [XLEN-1:0] o_rs2_data
);

    localparam int AW = $clog2(NUM_REGS);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic [AW-1:0]   rs1;
    logic [AW-1:0]   rs2;
    logic [AW-1:0]   rd;
    logic [XLEN-1:0] wb_data;

    // Upper index bits ignored when fewer registers are built
    assign rs1 = i_instr[15 +: AW];
    assign rs2 = i_instr[20 +: AW];
    assign rd  = i_instr[7 +: AW];

    always_comb begin
        case (i_ctrl.wb_source)
            WB_SOURCE_MEM_READ:     wb_data = i_load_data;
            WB_SOURCE_PC_PLUS_FOUR: wb_data = i_pc_plus_four;
            WB_SOURCE_SECOND_ADD:   wb_data = i_second_add_result;
            default:                wb_data = i_alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (i_ctrl.reg_write && rd != '0) begin
            regs[rd] <= wb_data;
        end
    end

    assign o_rs1_data = regs[rs1];
    assign o_rs2_data = regs[rs2];

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0);

endmodule

// ==== design/imm_ext.sv ====
`timescale 1ns/1ps

module imm_ext import holy_core_pkg::*; (
    input  logic [XLEN-1:0] i_instr,
    input  imm_source_t     i_imm_source,
    output logic [XLEN-1:0] o_imm
);

    logic sign;

    assign sign = i_instr[31];

    always_comb begin
        case (i_imm_source)
            IMM_S: o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
            // Branch offsets are in half-words
            IMM_B: o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
            IMM_U: o_imm = {i_instr[31:12], 12'b0};
            IMM_J: begin
                o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20],
                         i_instr[30:21], 1'b0};
            end
            default: o_imm = {{20{sign}}, i_instr[31:20]};
        endcase
    end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu import holy_core_pkg::*; (
    input  ctrl_t           i_ctrl,
    input  logic [XLEN-1:0] i_src1,
    input  logic [XLEN-1:0] i_rs2_data,
    input  logic [XLEN-1:0] i_imm,
    output logic [XLEN-1:0] o_result,
    output logic            o_zero,
    output logic            o_last_bit
);

    logic [XLEN-1:0] src2;
    logic [4:0]      shamt;

    assign src2  = (i_ctrl.alu_source == ALU_SOURCE_IMM) ? i_imm : i_rs2_data;
    assign shamt = src2[4:0];

    always_comb begin
        case (i_ctrl.alu_control)
            ALU_SUB:  o_result = i_src1 - src2;
            ALU_AND:  o_result = i_src1 & src2;
            ALU_OR:   o_result = i_src1 | src2;
            ALU_XOR:  o_result = i_src1 ^ src2;
            ALU_SLL:  o_result = i_src1 << shamt;
            ALU_SRL:  o_result = i_src1 >> shamt;
            ALU_SRA:  o_result = $unsigned($signed(i_src1) >>> shamt);
            ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, $signed(i_src1) < $signed(src2)};
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, i_src1 < src2};
            default:  o_result = i_src1 + src2;
        endcase
    end

    // Flags for the branch resolver
    assign o_zero     = (o_result == '0);
    assign o_last_bit = o_result[0];

endmodule

// ==== design/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit import holy_core_pkg::*; (
    input  logic            rst_n,
    input  ctrl_t           i_ctrl,
    input  logic [XLEN-1:0] i_addr,
    input  logic [XLEN-1:0] i_rs2_data,
    input  logic [XLEN-1:0] i_dmem_rdata,
    output dmem_req_t       o_dmem_req,
    output logic [XLEN-1:0] o_load_data
);

    logic [1:0]      offset;
    logic [XLEN-1:0] lane_data;

    assign offset = i_addr[1:0];

    // Store side, data shifted into the addressed lane
    always_comb begin
        o_dmem_req.addr = i_addr;
        case (i_ctrl.funct3[1:0])
            2'b00: begin
                o_dmem_req.wdata   = i_rs2_data << (8 * offset);
                o_dmem_req.byte_en = 4'b0001 << offset;
            end
            2'b01: begin
                o_dmem_req.wdata   = i_rs2_data << (16 * offset[1]);
                o_dmem_req.byte_en = 4'b0011 << {offset[1], 1'b0};
            end
            default: begin
                o_dmem_req.wdata   = i_rs2_data;
                o_dmem_req.byte_en = 4'b1111;
            end
        endcase
        o_dmem_req.write = rst_n && i_ctrl.mem_write;
        if (o_dmem_req.write) begin
            a_write_has_lanes: assert (o_dmem_req.byte_en != 4'b0000);
        end
    end

    // Load side, funct3[2] selects zero extension
    assign lane_data = i_dmem_rdata >> (8 * offset);

    always_comb begin
        case (i_ctrl.funct3)
            3'b000:  o_load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            3'b001:  o_load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            3'b100:  o_load_data = {24'b0, lane_data[7:0]};
            3'b101:  o_load_data = {16'b0, lane_data[15:0]};
            default: o_load_data = i_dmem_rdata;
        endcase
        if (!i_ctrl.mem_read) begin
            o_load_data = '0;
        end
    end

endmodule

// ==== design/holy_core.sv ====
`timescale 1ns/1ps

module holy_core import holy_core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0,
    parameter int              NUM_REGS = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic [XLEN-1:0] o_imem_addr,
    input  logic [XLEN-1:0] i_imem_rdata,
    output dmem_req_t       o_dmem_req,
    input  logic [XLEN-1:0] i_dmem_rdata
);

    ctrl_t           ctrl;
    logic            take_branch;
    logic            alu_zero;
    logic            alu_last_bit;
    logic [XLEN-1:0] pc_plus_four;
    logic [XLEN-1:0] second_add_result;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] load_data;

    pc_unit #(.RESET_PC(RESET_PC)) pc_unit_i (
        .clk, .rst_n,
        .i_ctrl(ctrl), .i_take_branch(take_branch), .i_imm(imm),
        .i_rs1_data(rs1_data), .i_alu_result(alu_result),
        .o_pc(o_imem_addr), .o_pc_plus_four(pc_plus_four),
        .o_second_add_result(second_add_result)
    );

    control control_i (
        .i_instr(i_imem_rdata), .i_alu_zero(alu_zero), .i_alu_last_bit(alu_last_bit),
        .o_ctrl(ctrl), .o_take_branch(take_branch)
    );

    regfile #(.NUM_REGS(NUM_REGS)) regfile_i (
        .clk, .rst_n,
        .i_instr(i_imem_rdata), .i_ctrl(ctrl),
        .i_alu_result(alu_result), .i_load_data(load_data),
        .i_pc_plus_four(pc_plus_four), .i_second_add_result(second_add_result),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    imm_ext imm_ext_i (.i_instr(i_imem_rdata), .i_imm_source(ctrl.imm_source), .o_imm(imm));

    alu alu_i (
        .i_ctrl(ctrl), .i_src1(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm),
        .o_result(alu_result), .o_zero(alu_zero), .o_last_bit(alu_last_bit)
    );

    load_store_unit load_store_unit_i (
        .rst_n, .i_ctrl(ctrl), .i_addr(alu_result), .i_rs2_data(rs2_data),
        .i_dmem_rdata(i_dmem_rdata), .o_dmem_req(o_dmem_req), .o_load_data(load_data)
    );

endmodule

// ==== testbench/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Architectural state of the model
logic [31:0] m_regs [32];
logic [31:0] m_mem [256];
logic [31:0] m_pc;

// Store issued by the last executed instruction
logic        m_st_valid;
logic [31:0] m_st_addr;
logic [3:0]  m_st_be;
logic [31:0] m_st_data;

function automatic logic [31:0] byte_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
endfunction

function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'd0, $signed(a) < $signed(b)};
        3'd3:    return {31'd0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        3'd7:    return a >= b;
        default: return 1'b0;
    endcase
endfunction

// Executes one instruction at m_pc
task automatic model_step(input logic [31:0] instr);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] nxt;
    logic [2:0]  f3;
    logic        wr;
    a          = m_regs[instr[19:15]];
    b          = m_regs[instr[24:20]];
    f3         = instr[14:12];
    imm_i      = {{20{instr[31]}}, instr[31:20]};
    imm_s      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    nxt        = m_pc + 32'd4;
    res        = 32'd0;
    wr         = 1'b1;
    m_st_valid = 1'b0;
    case (instr[6:0])
        7'b0110011: res = arith(f3, instr[30], a, b);
        7'b0010011: res = arith(f3, f3 == 3'd5 && instr[30], a, imm_i);
        7'b0000011: begin
            addr = a + imm_i;
            word = m_mem[addr[9:2]] >> (8 * addr[1:0]);
            case (f3)
                3'd0:    res = {{24{word[7]}}, word[7:0]};
                3'd1:    res = {{16{word[15]}}, word[15:0]};
                3'd4:    res = {24'd0, word[7:0]};
                3'd5:    res = {16'd0, word[15:0]};
                default: res = word;
            endcase
        end
        7'b0100011: begin
            wr         = 1'b0;
            addr       = a + imm_s;
            m_st_valid = 1'b1;
            m_st_addr  = addr;
            // Value copied to every lane, enables pick the live ones
            if (f3 == 3'd0) begin
                m_st_be   = 4'b0001 << addr[1:0];
                m_st_data = {4{b[7:0]}};
            end else if (f3 == 3'd1) begin
                m_st_be   = 4'b0011 << addr[1:0];
                m_st_data = {2{b[15:0]}};
            end else begin
                m_st_be   = 4'b1111;
                m_st_data = b;
            end
            m_st_data        = m_st_data & byte_mask(m_st_be);
            m_mem[addr[9:2]] = (m_mem[addr[9:2]] & ~byte_mask(m_st_be)) | m_st_data;
        end
        7'b1100011: begin
            wr = 1'b0;
            if (branch_taken(f3, a, b)) begin
                nxt = m_pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
        end
        7'b1101111: begin
            res = m_pc + 32'd4;
            nxt = m_pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        end
        7'b1100111: begin
            res = m_pc + 32'd4;
            nxt = (a + imm_i) & ~32'd1;
        end
        7'b0110111: res = {instr[31:12], 12'd0};
        7'b0010111: res = m_pc + {instr[31:12], 12'd0};
        // FENCE, ECALL and anything unknown
        default:    wr = 1'b0;
    endcase
    if (wr && instr[11:7] != 5'd0) begin
        m_regs[instr[11:7]] = res;
    end
    m_pc = nxt;
endtask

`endif

// ==== testbench/tb_holy_core.sv ====
`timescale 1ns/1ps

module tb_holy_core import holy_core_pkg::*; ();

    localparam logic [31:0] RESET_PC       = 32'h0;
    localparam int          PROG_LEN       = 400;
    localparam int          RUN_CYCLES     = 600;
    localparam int          TIMEOUT_CYCLES = 2 * PROG_LEN + 100;

    logic        clk   = 1'b0;
    logic        rst_n = 1'b0;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    dmem_req_t   dmem_req;
    logic [31:0] dmem_rdata;
    logic [31:0] imem [1024];
    logic [31:0] dmem [256];
    int          cycle_count = 0;

    `include "rv_ref_model.svh"

    holy_core #(.RESET_PC(RESET_PC), .NUM_REGS(32)) dut_i (
        .clk, .rst_n,
        .o_imem_addr(imem_addr), .i_imem_rdata(imem_rdata),
        .o_dmem_req(dmem_req), .i_dmem_rdata(dmem_rdata)
    );

    always #10 clk = ~clk;

    assign imem_rdata = imem[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    // Byte-lane write at the clock edge
    always @(posedge clk) begin
        if (dmem_req.write) begin
            dmem[dmem_req.addr[9:2]] <= (dmem[dmem_req.addr[9:2]] & ~byte_mask(dmem_req.byte_en))
                                       | (dmem_req.wdata & byte_mask(dmem_req.byte_en));
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] fill_word(input int idx);
        return {idx[7:0], ~idx[7:0], idx[7:0] ^ 8'h5a, 8'(idx * 37)};
    endfunction

    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic build_program();
        int          idx;
        int          tgt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        for (idx = 0; idx < 1024; idx++) begin
            // ADDI x0 with the word index as immediate
            imem[idx] = {2'b00, idx[9:0], 13'd0, 7'b0010011};
        end
        // x1 points at the data region
        imem[0] = i_format(12'h100, 5'd0, 3'd0, 5'd1, 7'b0010011);
        for (idx = 1; idx < PROG_LEN - 1; idx++) begin
            rd  = ($urandom_range(0, 15) == 0) ? 5'd0 : 5'($urandom_range(2, 15));
            rs1 = 5'($urandom_range(0, 15));
            rs2 = 5'($urandom_range(0, 15));
            f3  = 3'($urandom_range(0, 7));
            imm = 12'($urandom);
            alt = 1'($urandom_range(0, 1));
            tgt = idx + int'($urandom_range(1, 4));
            if (tgt > PROG_LEN - 1) begin
                tgt = PROG_LEN - 1;
            end
            case ($urandom_range(0, 11))
                0, 1, 2: begin
                    alt       = alt && (f3 == 3'd0 || f3 == 3'd5);
                    imem[idx] = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
                end
                3, 4: begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        imm = {1'b0, alt && f3 == 3'd5, 5'd0, imm[4:0]};
                    end
                    imem[idx] = i_format(imm, rs1, f3, rd, 7'b0010011);
                end
                5: imem[idx] = {20'($urandom), rd, 7'b0110111};
                6: imem[idx] = {20'($urandom), rd, 7'b0010111};
                7: begin
                    f3 = 3'($urandom_range(0, 4));
                    if (f3 == 3'd3) begin
                        f3 = 3'd5;
                    end
                    imm       = 12'($urandom_range(0, 255)) & ~((12'd1 << f3[1:0]) - 12'd1);
                    imem[idx] = i_format(imm, 5'd1, f3, rd, 7'b0000011);
                end
                8: begin
                    f3        = 3'($urandom_range(0, 2));
                    imm       = 12'($urandom_range(0, 255)) & ~((12'd1 << f3[1:0]) - 12'd1);
                    imem[idx] = s_format(imm, rs2, 5'd1, f3);
                end
                9: begin
                    f3 = 3'($urandom_range(0, 5));
                    if (f3 >= 3'd2) begin
                        f3 = f3 + 3'd2;
                    end
                    imem[idx] = b_format(13'(4 * (tgt - idx)), rs2, rs1, f3);
                end
                10: begin
                    if (alt) begin
                        imem[idx] = j_format(21'(4 * (tgt - idx)), rd);
                    end else begin
                        // Absolute target off x0, bit 0 sometimes set
                        imm       = 12'(4 * tgt + int'($urandom_range(0, 1)));
                        imem[idx] = i_format(imm, 5'd0, 3'd0, rd, 7'b1100111);
                    end
                end
                default: imem[idx] = alt ? 32'h0000_000f : 32'h0000_0073;
            endcase
        end
        imem[PROG_LEN - 1] = j_format(21'd0, 5'd0);
    endtask

    initial begin
        int          seed_word;
        int          i;
        logic [31:0] first_instr;
        seed_word = $urandom(88374);
        build_program();
        m_regs = '{default: '0};
        m_pc   = RESET_PC;
        for (i = 0; i < 256; i++) begin
            dmem[i]  <= fill_word(i);
            m_mem[i] = fill_word(i);
        end
        // A store at the reset PC must stay masked while in reset
        first_instr          = imem[RESET_PC[11:2]];
        imem[RESET_PC[11:2]] = s_format(12'h100, 5'd0, 5'd0, 3'd2);
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            check_value("o_imem_addr", RESET_PC, imem_addr);
            check_value("o_dmem_req.write", 32'd0, 32'(dmem_req.write));
            @(posedge clk);
        end
        imem[RESET_PC[11:2]] = first_instr;
        rst_n <= 1'b1;
        for (i = 0; i < RUN_CYCLES; i++) begin
            @(negedge clk);
            if (i == 0) begin
                check_value("o_imem_addr", RESET_PC, imem_addr);
                check_value("o_dmem_req.write", 32'd0, 32'(dmem_req.write));
            end
            check_value("o_imem_addr", m_pc, imem_addr);
            model_step(imem[m_pc[11:2]]);
            check_value("o_dmem_req.write", 32'(m_st_valid), 32'(dmem_req.write));
            if (m_st_valid) begin
                check_value("o_dmem_req.addr", m_st_addr, dmem_req.addr);
                check_value("o_dmem_req.byte_en", 32'(m_st_be), 32'(dmem_req.byte_en));
                check_value("o_dmem_req.wdata", m_st_data,
                            dmem_req.wdata & byte_mask(dmem_req.byte_en));
            end
        end
        // Let the last store land
        @(negedge clk);
        for (i = 0; i < 256; i++) begin
            check_value($sformatf("dmem[%0d]", i), m_mem[i], dmem[i]);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== holy_core.f ====
+incdir+testbench
design/holy_core_pkg.sv
design/pc_unit.sv
design/control.sv
design/regfile.sv
design/imm_ext.sv
design/alu.sv
design/load_store_unit.sv
design/holy_core.sv
testbench/tb_holy_core.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f holy_core.f --top-module tb_holy_core -Mdir obj_dir
	./obj_dir/Vtb_holy_core

clean:
	rm -rf obj_dir
